/* verilog/soc_bus_pkg.sv */
/*
 * Bus-wide widths, response codes and request types for the fabric.
 * Imported by the queue, the interconnect, both slaves and the top level.
 */
package soc_bus_pkg;

  localparam int ADDR_W     = 40;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;
  localparam int REGION_W   = 8;
  localparam int OFFSET_W   = ADDR_W - REGION_W;
  localparam int WORD_IDX_W = ADDR_W - 2;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  // one address word with two views
  // the interconnect decodes the region, the slaves index by word
  typedef union packed {
    struct packed {
      logic [REGION_W-1:0] region;
      logic [OFFSET_W-1:0] offset;
    } rgn;
    struct packed {
      logic [WORD_IDX_W-1:0] index;
      logic [1:0]            lane;
    } word;
  } bus_addr_u;

  typedef struct packed {
    logic              write;
    bus_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } req_t;

endpackage

/* verilog/soc_map_pkg.sv */
/*
 * Address map of the fabric and the GPIO register offsets.
 * Regions other than SRAM and GPIO get a decode error.
 */
package soc_map_pkg;

  // top address byte selects the region
  localparam logic [7:0] REGION_SRAM = 8'h00;
  localparam logic [7:0] REGION_GPIO = 8'h01;

  // byte offsets inside the GPIO region
  localparam logic [31:0] GPIO_DATA_OUT = 32'h0000_0000;
  localparam logic [31:0] GPIO_DIR      = 32'h0000_0004;
  localparam logic [31:0] GPIO_DATA_IN  = 32'h0000_0008;

  localparam int GPIO_W = 8;

endpackage

/* verilog/req_queue.sv */
`timescale 1ns/1ps
/*
 * Request FIFO between the external master and the interconnect.
 * Ready stays high while there is room, or when the head leaves this cycle.
 */
module req_queue #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                             i_pad_clk,
  input  logic                             i_rst_n,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [soc_bus_pkg::ADDR_W-1:0]   i_req_addr,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_req_wdata,
  input  logic [soc_bus_pkg::STRB_W-1:0]   i_req_wstrb,
  input  logic                             i_pop,
  output logic                             o_req_ready,
  output logic                             o_head_valid,
  output logic                             o_head_write,
  output soc_bus_pkg::bus_addr_u           o_head_addr,
  output logic [soc_bus_pkg::DATA_W-1:0]   o_head_wdata,
  output logic [soc_bus_pkg::STRB_W-1:0]   o_head_wstrb
);
  import soc_bus_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  req_t             mem [FIFO_DEPTH];
  req_t             head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;

  // wrap by hand so any depth works
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(FIFO_DEPTH));
  assign o_req_ready = ~full | i_pop;
  assign push        = i_req_valid & o_req_ready;

  always_ff @(posedge i_pad_clk) begin
    if (push) begin
      mem[wr_ptr] <= {i_req_write, i_req_addr, i_req_wdata, i_req_wstrb};
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (i_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head         = mem[rd_ptr];
  assign o_head_valid = (count != '0);
  assign o_head_write = head.write;
  assign o_head_addr  = head.addr;
  assign o_head_wdata = head.wdata;
  assign o_head_wstrb = head.wstrb;

endmodule

/* verilog/bus_interconnect.sv */
`timescale 1ns/1ps
/*
 * Decodes the queue head by region and strobes the SRAM or GPIO slave.
 * Unmapped regions get a DECERR reply; one transaction is in service at a time.
 */
module bus_interconnect (
  input  logic                             i_pad_clk,
  input  logic                             i_rst_n,
  input  logic                             i_head_valid,
  input  logic                             i_head_write,
  input  soc_bus_pkg::bus_addr_u           i_head_addr,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_head_wdata,
  input  logic [soc_bus_pkg::STRB_W-1:0]   i_head_wstrb,
  input  logic                             i_rsp_ready,
  input  logic                             i_sram_done,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_sram_rdata,
  input  soc_bus_pkg::resp_e               i_sram_resp,
  input  logic                             i_gpio_done,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_gpio_rdata,
  input  soc_bus_pkg::resp_e               i_gpio_resp,
  output logic                             o_pop,
  output logic                             o_sram_sel,
  output logic                             o_gpio_sel,
  output logic                             o_slv_write,
  output soc_bus_pkg::bus_addr_u           o_slv_addr,
  output logic [soc_bus_pkg::DATA_W-1:0]   o_slv_wdata,
  output logic [soc_bus_pkg::STRB_W-1:0]   o_slv_wstrb,
  output logic                             o_rsp_valid,
  output logic [soc_bus_pkg::DATA_W-1:0]   o_rsp_rdata,
  output soc_bus_pkg::resp_e               o_rsp_resp
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  req_t head;
  logic busy;
  logic hit_sram;
  logic hit_gpio;
  logic dec_err;
  logic reply_valid;
  logic rsp_accept;

  // head fields back into one request word
  assign head = {i_head_write, i_head_addr, i_head_wdata, i_head_wstrb};

  assign hit_sram = (head.addr.rgn.region == REGION_SRAM);
  assign hit_gpio = (head.addr.rgn.region == REGION_GPIO);

  assign o_pop      = i_head_valid & ~busy;
  assign o_sram_sel = o_pop & hit_sram;
  assign o_gpio_sel = o_pop & hit_gpio;

  assign o_slv_write = head.write;
  assign o_slv_addr  = head.addr;
  assign o_slv_wdata = head.wdata;
  assign o_slv_wstrb = head.wstrb;

  // decode error lines up with a slave done pulse
  assign reply_valid = i_sram_done | i_gpio_done | dec_err;
  assign rsp_accept  = o_rsp_valid & i_rsp_ready;

  always_ff @(posedge i_pad_clk) begin
    if (!i_rst_n) begin
      busy        <= 1'b0;
      dec_err     <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      if (o_pop) begin
        busy <= 1'b1;
      end else if (rsp_accept) begin
        busy <= 1'b0;
      end
      dec_err <= o_pop & ~hit_sram & ~hit_gpio;
      if (reply_valid) begin
        o_rsp_valid <= 1'b1;
      end else if (rsp_accept) begin
        o_rsp_valid <= 1'b0;
      end
    end
  end

  // reply of whichever slave finished
  always_ff @(posedge i_pad_clk) begin
    if (reply_valid) begin
      if (i_sram_done) begin
        o_rsp_rdata <= i_sram_rdata;
        o_rsp_resp  <= i_sram_resp;
      end else if (i_gpio_done) begin
        o_rsp_rdata <= i_gpio_rdata;
        o_rsp_resp  <= i_gpio_resp;
      end else begin
        o_rsp_rdata <= '0;
        o_rsp_resp  <= RESP_DECERR;
      end
    end
  end

endmodule

/* verilog/sram_slave.sv */
`timescale 1ns/1ps
/*
 * On-chip word SRAM with byte strobes, answered one cycle after the strobe.
 * Word indices past the end of the array return SLVERR.
 */
module sram_slave #(
  parameter int MEM_WORDS = 256
) (
  input  logic                             i_pad_clk,
  input  logic                             i_rst_n,
  input  logic                             i_sel,
  input  logic                             i_write,
  input  soc_bus_pkg::bus_addr_u           i_addr,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_wdata,
  input  logic [soc_bus_pkg::STRB_W-1:0]   i_wstrb,
  output logic                             o_done,
  output logic [soc_bus_pkg::DATA_W-1:0]   o_rdata,
  output soc_bus_pkg::resp_e               o_resp
);
  import soc_bus_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              in_range;

  assign in_range = (i_addr.word.index < WORD_IDX_W'(MEM_WORDS));
  assign idx      = i_addr.word.index[IDX_W-1:0];

  always_ff @(posedge i_pad_clk) begin
    if (!i_rst_n) begin
      o_done <= 1'b0;
    end else begin
      o_done <= i_sel;
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (i_sel) begin
      o_rdata <= '0;
      o_resp  <= RESP_OKAY;
      if (!in_range) begin
        o_resp <= RESP_SLVERR;
      end else if (i_write) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (i_wstrb[b]) begin
            mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end else begin
        o_rdata <= mem[idx];
      end
    end
  end

endmodule

/* verilog/gpio_regs.sv */
`timescale 1ns/1ps
/*
 * GPIO data-out and direction registers plus a synchronized input port.
 * Writes take the low data byte; strobes play no part here.
 */
module gpio_regs (
  input  logic                             i_pad_clk,
  input  logic                             i_rst_n,
  input  logic                             i_sel,
  input  logic                             i_write,
  input  soc_bus_pkg::bus_addr_u           i_addr,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_wdata,
  input  logic [soc_map_pkg::GPIO_W-1:0]   i_gpio_in,
  output logic                             o_done,
  output logic [soc_bus_pkg::DATA_W-1:0]   o_rdata,
  output soc_bus_pkg::resp_e               o_resp,
  output logic [soc_map_pkg::GPIO_W-1:0]   o_gpio_out,
  output logic [soc_map_pkg::GPIO_W-1:0]   o_gpio_oe
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [GPIO_W-1:0] data_out_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] sync_q1;
  logic [GPIO_W-1:0] sync_q2;

  always_ff @(posedge i_pad_clk) begin
    if (!i_rst_n) begin
      o_done     <= 1'b0;
      data_out_q <= '0;
      dir_q      <= '0;
      sync_q1    <= '0;
      sync_q2    <= '0;
    end else begin
      o_done  <= i_sel;
      // two-flop synchronizer on the pad input
      sync_q1 <= i_gpio_in;
      sync_q2 <= sync_q1;
      if (i_sel && i_write && i_addr.rgn.offset == GPIO_DATA_OUT) begin
        data_out_q <= i_wdata[GPIO_W-1:0];
      end
      if (i_sel && i_write && i_addr.rgn.offset == GPIO_DIR) begin
        dir_q <= i_wdata[GPIO_W-1:0];
      end
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (i_sel) begin
      o_rdata <= '0;
      o_resp  <= RESP_OKAY;
      case (i_addr.rgn.offset)
        GPIO_DATA_OUT: if (!i_write) o_rdata <= DATA_W'(data_out_q);
        GPIO_DIR:      if (!i_write) o_rdata <= DATA_W'(dir_q);
        GPIO_DATA_IN: begin
          // input port is read only
          if (i_write) begin
            o_resp <= RESP_SLVERR;
          end else begin
            o_rdata <= DATA_W'(sync_q2);
          end
        end
        default:       o_resp <= RESP_SLVERR;
      endcase
    end
  end

  assign o_gpio_out = data_out_q;
  assign o_gpio_oe  = dir_q;

endmodule

/* verilog/soc_fabric.sv */
`timescale 1ns/1ps
/*
 * Top level of the system fabric: request queue, interconnect, SRAM and GPIO.
 * An external master drives the request channel and takes in-order responses.
 */
module soc_fabric #(
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_WORDS  = 256
) (
  input  logic                             i_pad_clk,
  input  logic                             i_rst_n,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [soc_bus_pkg::ADDR_W-1:0]   i_req_addr,
  input  logic [soc_bus_pkg::DATA_W-1:0]   i_req_wdata,
  input  logic [soc_bus_pkg::STRB_W-1:0]   i_req_wstrb,
  input  logic                             i_rsp_ready,
  input  logic [soc_map_pkg::GPIO_W-1:0]   i_gpio_in,
  output logic                             o_req_ready,
  output logic                             o_rsp_valid,
  output logic [soc_bus_pkg::DATA_W-1:0]   o_rsp_rdata,
  output soc_bus_pkg::resp_e               o_rsp_resp,
  output logic [soc_map_pkg::GPIO_W-1:0]   o_gpio_out,
  output logic [soc_map_pkg::GPIO_W-1:0]   o_gpio_oe
);
  import soc_bus_pkg::*;

  logic              head_valid;
  logic              head_write;
  bus_addr_u         head_addr;
  logic [DATA_W-1:0] head_wdata;
  logic [STRB_W-1:0] head_wstrb;
  logic              pop;
  logic              sram_sel;
  logic              gpio_sel;
  logic              slv_write;
  bus_addr_u         slv_addr;
  logic [DATA_W-1:0] slv_wdata;
  logic [STRB_W-1:0] slv_wstrb;
  logic              sram_done;
  logic [DATA_W-1:0] sram_rdata;
  resp_e             sram_resp;
  logic              gpio_done;
  logic [DATA_W-1:0] gpio_rdata;
  resp_e             gpio_resp;

  req_queue #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) x_req_queue (
    .i_pad_clk    (i_pad_clk  ),
    .i_rst_n      (i_rst_n    ),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr ),
    .i_req_wdata  (i_req_wdata),
    .i_req_wstrb  (i_req_wstrb),
    .i_pop        (pop        ),
    .o_req_ready  (o_req_ready),
    .o_head_valid (head_valid ),
    .o_head_write (head_write ),
    .o_head_addr  (head_addr  ),
    .o_head_wdata (head_wdata ),
    .o_head_wstrb (head_wstrb )
  );

  bus_interconnect x_bus_interconnect (
    .i_pad_clk    (i_pad_clk  ),
    .i_rst_n      (i_rst_n    ),
    .i_head_valid (head_valid ),
    .i_head_write (head_write ),
    .i_head_addr  (head_addr  ),
    .i_head_wdata (head_wdata ),
    .i_head_wstrb (head_wstrb ),
    .i_rsp_ready  (i_rsp_ready),
    .i_sram_done  (sram_done  ),
    .i_sram_rdata (sram_rdata ),
    .i_sram_resp  (sram_resp  ),
    .i_gpio_done  (gpio_done  ),
    .i_gpio_rdata (gpio_rdata ),
    .i_gpio_resp  (gpio_resp  ),
    .o_pop        (pop        ),
    .o_sram_sel   (sram_sel   ),
    .o_gpio_sel   (gpio_sel   ),
    .o_slv_write  (slv_write  ),
    .o_slv_addr   (slv_addr   ),
    .o_slv_wdata  (slv_wdata  ),
    .o_slv_wstrb  (slv_wstrb  ),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_rdata  (o_rsp_rdata),
    .o_rsp_resp   (o_rsp_resp )
  );

  sram_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) x_sram_slave (
    .i_pad_clk (i_pad_clk ),
    .i_rst_n   (i_rst_n   ),
    .i_sel     (sram_sel  ),
    .i_write   (slv_write ),
    .i_addr    (slv_addr  ),
    .i_wdata   (slv_wdata ),
    .i_wstrb   (slv_wstrb ),
    .o_done    (sram_done ),
    .o_rdata   (sram_rdata),
    .o_resp    (sram_resp )
  );

  // gpio ignores the byte strobes
  gpio_regs x_gpio_regs (
    .i_pad_clk  (i_pad_clk ),
    .i_rst_n    (i_rst_n   ),
    .i_sel      (gpio_sel  ),
    .i_write    (slv_write ),
    .i_addr     (slv_addr  ),
    .i_wdata    (slv_wdata ),
    .i_gpio_in  (i_gpio_in ),
    .o_done     (gpio_done ),
    .o_rdata    (gpio_rdata),
    .o_resp     (gpio_resp ),
    .o_gpio_out (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe )
  );

endmodule

/* bench/soc_fabric_tb.sv */
`timescale 1ns/1ps
/*
 * Testbench for the fabric top level. Drives single-beat requests, keeps a
 * model of the SRAM and GPIO, and checks each accepted response in order.
 */
module soc_fabric_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  // about 80 requests at 3 to 4 cycles each, plus reset, gpio waits and hold
  localparam int MAX_CYCLES = 2000;
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  logic        i_pad_clk;
  logic        i_rst_n;
  logic        i_req_valid;
  logic        i_req_write;
  logic [39:0] i_req_addr;
  logic [31:0] i_req_wdata;
  logic [3:0]  i_req_wstrb;
  logic        i_rsp_ready;
  logic [7:0]  i_gpio_in;
  logic        o_req_ready;
  logic        o_rsp_valid;
  logic [31:0] o_rsp_rdata;
  logic [1:0]  o_rsp_resp;
  logic [7:0]  o_gpio_out;
  logic [7:0]  o_gpio_oe;

  // reference model and expected responses
  logic [31:0] sram_model [MEM_WORDS];
  logic [7:0]  gpio_out_model = '0;
  logic [7:0]  gpio_dir_model = '0;
  logic [31:0] exp_rdata_q [$];
  logic [1:0]  exp_resp_q [$];
  string       exp_test_q [$];
  logic [31:0] exp_rdata = '0;
  logic [1:0]  exp_resp = '0;
  string       exp_test = "";
  logic        exp_valid = 1'b0;
  int          pending = 0;

  // handshake snapshots taken at the falling edge
  logic        req_fire = 1'b0;
  logic        rsp_fire = 1'b0;
  logic        hold_snap = 1'b0;
  logic        hold_prev = 1'b0;
  logic [31:0] rdata_snap;
  logic [31:0] rdata_prev;
  logic [1:0]  resp_snap;
  logic [1:0]  resp_prev;

  string       cur_test = "none";
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          test_fail = 0;
  int          test_err_start = 0;
  int          cycle_cnt = 0;
  logic        saw_full = 1'b0;
  logic [31:0] rng_state;

  soc_fabric #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .MEM_WORDS  (MEM_WORDS )
  ) DUT (
    .i_pad_clk   (i_pad_clk  ),
    .i_rst_n     (i_rst_n    ),
    .i_req_valid (i_req_valid),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr ),
    .i_req_wdata (i_req_wdata),
    .i_req_wstrb (i_req_wstrb),
    .i_rsp_ready (i_rsp_ready),
    .i_gpio_in   (i_gpio_in  ),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_resp  (o_rsp_resp ),
    .o_gpio_out  (o_gpio_out ),
    .o_gpio_oe   (o_gpio_oe  )
  );

  initial begin
    i_pad_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_pad_clk = ~i_pad_clk;
  end

  always @(posedge i_pad_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles in test %s with %0d responses outstanding",
               cycle_cnt, cur_test, pending);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [39:0] sram_addr(input int idx);
    return {8'h00, 32'(idx << 2)};
  endfunction

  // expected reply per the address map rules
  function automatic void model_request(input logic wr, input logic [39:0] addr,
                                        input logic [31:0] wdata, input logic [3:0] wstrb);
    logic [31:0] rdata;
    logic [1:0]  resp;
    logic [37:0] index;
    logic [31:0] offset;
    rdata  = '0;
    resp   = RESP_OKAY;
    index  = addr[39:2];
    offset = addr[31:0];
    if (addr[39:32] == 8'h00) begin
      if (index >= 38'(MEM_WORDS)) begin
        resp = RESP_SLVERR;
      end else if (wr) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            sram_model[int'(index)][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end else begin
        rdata = sram_model[int'(index)];
      end
    end else if (addr[39:32] == 8'h01) begin
      if (offset == 32'h0 && wr) begin
        gpio_out_model = wdata[7:0];
      end else if (offset == 32'h0) begin
        rdata = {24'h0, gpio_out_model};
      end else if (offset == 32'h4 && wr) begin
        gpio_dir_model = wdata[7:0];
      end else if (offset == 32'h4) begin
        rdata = {24'h0, gpio_dir_model};
      end else if (offset == 32'h8 && !wr) begin
        rdata = {24'h0, i_gpio_in};
      end else begin
        resp = RESP_SLVERR;
      end
    end else begin
      resp = RESP_DECERR;
    end
    exp_rdata_q.push_back(rdata);
    exp_resp_q.push_back(resp);
    exp_test_q.push_back(cur_test);
    pending++;
  endfunction

  always @(negedge i_pad_clk) begin
    req_fire   = i_rst_n & i_req_valid & o_req_ready;
    rsp_fire   = i_rst_n & o_rsp_valid & i_rsp_ready;
    hold_snap  = i_rst_n & o_rsp_valid & ~i_rsp_ready;
    rdata_snap = o_rsp_rdata;
    resp_snap  = o_rsp_resp;
  end

  always @(posedge i_pad_clk) begin
    if (req_fire) begin
      model_request(i_req_write, i_req_addr, i_req_wdata, i_req_wstrb);
    end
    if (rsp_fire && exp_rdata_q.size() != 0) begin
      void'(exp_rdata_q.pop_front());
      void'(exp_resp_q.pop_front());
      void'(exp_test_q.pop_front());
      pending--;
    end
    exp_valid = (exp_rdata_q.size() != 0);
    if (exp_valid) begin
      exp_rdata = exp_rdata_q[0];
      exp_resp  = exp_resp_q[0];
      exp_test  = exp_test_q[0];
    end
    hold_prev  = hold_snap;
    rdata_prev = rdata_snap;
    resp_prev  = resp_snap;
  end

  rsp_matches: assert property (@(negedge i_pad_clk) disable iff (!i_rst_n)
    (o_rsp_valid && i_rsp_ready && exp_valid) |->
    (o_rsp_rdata == exp_rdata && o_rsp_resp == exp_resp))
    else begin
      $display("** Error [%s] expected resp %0d rdata %h, actual resp %0d rdata %h",
               exp_test, exp_resp, exp_rdata, o_rsp_resp, o_rsp_rdata);
      err_cnt++;
    end

  rsp_expected: assert property (@(negedge i_pad_clk) disable iff (!i_rst_n)
    (o_rsp_valid && i_rsp_ready) |-> exp_valid)
    else begin
      $display("[%s] a response arrived with no request outstanding", cur_test);
      err_cnt++;
    end

  rsp_stable: assert property (@(negedge i_pad_clk) disable iff (!i_rst_n)
    hold_prev |-> (o_rsp_valid && o_rsp_rdata == rdata_prev && o_rsp_resp == resp_prev))
    else begin
      $display("** Error [%s] held response expected valid resp %0d rdata %h, actual %0d %0d %h",
               cur_test, resp_prev, rdata_prev, o_rsp_valid, o_rsp_resp, o_rsp_rdata);
      err_cnt++;
    end

  // pins follow the model whenever nothing is outstanding
  gpio_pins: assert property (@(negedge i_pad_clk) disable iff (!i_rst_n)
    (pending == 0) |-> (o_gpio_out == gpio_out_model && o_gpio_oe == gpio_dir_model))
    else begin
      $display("** Error [%s] gpio expected out %h oe %h, actual out %h oe %h",
               cur_test, gpio_out_model, gpio_dir_model, o_gpio_out, o_gpio_oe);
      err_cnt++;
    end

  task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    value_ok: assert (exp === act) else begin
      $display("** Error [%s] %s expected %h actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic send_req(input logic wr, input logic [39:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb);
    i_req_valid = 1'b1;
    i_req_write = wr;
    i_req_addr  = addr;
    i_req_wdata = wdata;
    i_req_wstrb = wstrb;
    @(negedge i_pad_clk);
    while (!o_req_ready) @(negedge i_pad_clk);
    @(posedge i_pad_clk);
    #DRIVE_DLY;
    i_req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    do @(negedge i_pad_clk); while (pending != 0);
    @(posedge i_pad_clk);
    #DRIVE_DLY;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic finish_test();
    wait_idle();
    test_cnt++;
    if (err_cnt == test_err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
    end
  endtask

  task automatic check_reset();
    start_test("reset");
    @(negedge i_pad_clk);
    expect_equal("o_rsp_valid", 32'h0, 32'(o_rsp_valid));
    expect_equal("o_req_ready", 32'h1, 32'(o_req_ready));
    expect_equal("o_gpio_out", 32'h0, 32'(o_gpio_out));
    expect_equal("o_gpio_oe", 32'h0, 32'(o_gpio_oe));
    finish_test();
  endtask

  task automatic check_sram();
    int          idx_list [16];
    logic [31:0] r;
    start_test("sram");
    for (int i = 0; i < 16; i++) begin
      idx_list[i] = int'(lcg_next() % 32'(MEM_WORDS));
      send_req(1'b1, sram_addr(idx_list[i]), lcg_next(), 4'hf);
    end
    // low bits of the generator repeat, so strobes come from the top nibble
    for (int i = 0; i < 16; i++) begin
      r = lcg_next();
      send_req(1'b1, sram_addr(idx_list[i]), lcg_next(), r[31:28]);
    end
    for (int i = 0; i < 16; i++) begin
      send_req(1'b0, sram_addr(idx_list[i]), lcg_next(), 4'hf);
    end
    // index MEM_WORDS would alias word 0 without the range check
    send_req(1'b1, sram_addr(0), lcg_next(), 4'hf);
    send_req(1'b1, sram_addr(MEM_WORDS), 32'hdead_beef, 4'hf);
    send_req(1'b0, sram_addr(MEM_WORDS + 37), 32'h0, 4'hf);
    send_req(1'b0, {8'h00, 32'hffff_fffc}, 32'h0, 4'hf);
    send_req(1'b0, sram_addr(0), 32'h0, 4'hf);
    finish_test();
  endtask

  task automatic check_decerr();
    start_test("decerr");
    send_req(1'b1, {8'h02, lcg_next()}, lcg_next(), 4'hf);
    send_req(1'b0, {8'h02, lcg_next()}, lcg_next(), 4'hf);
    send_req(1'b0, {8'h7f, 32'h0}, 32'h0, 4'h0);
    send_req(1'b1, {8'hff, 32'h4}, lcg_next(), 4'h3);
    send_req(1'b0, {8'hff, 32'hffff_fffc}, 32'h0, 4'hf);
    finish_test();
  endtask

  task automatic check_gpio();
    start_test("gpio");
    // strobes play no part in gpio writes
    send_req(1'b1, {8'h01, 32'h0}, lcg_next(), 4'h0);
    send_req(1'b1, {8'h01, 32'h4}, lcg_next(), 4'hf);
    send_req(1'b0, {8'h01, 32'h0}, 32'h0, 4'hf);
    send_req(1'b0, {8'h01, 32'h4}, 32'h0, 4'hf);
    wait_idle();
    i_gpio_in = 8'h3c;
    repeat (3) @(posedge i_pad_clk);
    #DRIVE_DLY;
    send_req(1'b0, {8'h01, 32'h8}, 32'h0, 4'hf);
    i_gpio_in = 8'hc5;
    repeat (4) @(posedge i_pad_clk);
    #DRIVE_DLY;
    send_req(1'b0, {8'h01, 32'h8}, 32'h0, 4'hf);
    send_req(1'b1, {8'h01, 32'h8}, lcg_next(), 4'hf);
    send_req(1'b0, {8'h01, 32'hc}, 32'h0, 4'hf);
    send_req(1'b1, {8'h01, 32'h0}, 32'h0000_005a, 4'hf);
    finish_test();
  endtask

  task automatic check_backpressure();
    start_test("backpressure");
    i_rsp_ready = 1'b0;
    saw_full    = 1'b0;
    fork
      begin
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
          if (i % 2 == 0) begin
            send_req(1'b1, sram_addr(40 + i), lcg_next(), 4'hf);
          end else begin
            send_req(1'b0, sram_addr(39 + i), 32'h0, 4'hf);
          end
        end
        send_req(1'b0, {8'h05, 32'h10}, 32'h0, 4'hf);
      end
      begin
        for (int c = 0; c < 40 && !saw_full; c++) begin
          @(negedge i_pad_clk);
          if (!o_req_ready) begin
            saw_full = 1'b1;
          end
        end
        // hold a few cycles with the queue full
        repeat (4) @(posedge i_pad_clk);
        #DRIVE_DLY;
        i_rsp_ready = 1'b1;
      end
    join
    queue_filled: assert (saw_full) else begin
      $display("[%s] o_req_ready never dropped while responses were held", cur_test);
      err_cnt++;
    end
    finish_test();
  endtask

  initial begin
    rng_state   = 32'h92b7_f83a;
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr  = '0;
    i_req_wdata = '0;
    i_req_wstrb = '0;
    i_rsp_ready = 1'b1;
    i_gpio_in   = '0;
    repeat (10) @(posedge i_pad_clk);
    #DRIVE_DLY;
    i_rst_n = 1'b1;
    check_reset();
    check_sram();
    check_decerr();
    check_gpio();
    check_backpressure();
    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* soc_fabric.f */
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/req_queue.sv
verilog/bus_interconnect.sv
verilog/sram_slave.sv
verilog/gpio_regs.sv
verilog/soc_fabric.sv
bench/soc_fabric_tb.sv

/* Makefile */
# Verilator flow for the soc_fabric testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= soc_fabric_tb
DUT_TOP   ?= soc_fabric
FILELIST  ?= soc_fabric.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides the result, not the exit code of the run
sim: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
